// File: common/fir_pkg.sv
package fir_pkg;

  //////////////////////////////////////////////////
  // Filter dimensions
  //////////////////////////////////////////////////

  localparam int NUM_TAPS  = 8;
  localparam int COEF_W    = 16;
  localparam int SAMPLE_W  = 16;
  localparam int PROD_W    = SAMPLE_W + COEF_W;
  // Full sum of all taps without overflow
  localparam int ACC_W     = SAMPLE_W + COEF_W + $clog2(NUM_TAPS);
  localparam int OUT_SHIFT = 15;

  // Returned for readback selects with no meaning
  localparam logic [63:0] RB_BAD_WORD = 64'h0BAD_C0DE_0BAD_C0DE;

  //////////////////////////////////////////////////
  // Stream types
  //////////////////////////////////////////////////

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } sample_t;

  typedef struct packed {
    sample_t sample;
    logic    last;
  } stream_beat_t;

  //////////////////////////////////////////////////
  // Coefficient types
  //////////////////////////////////////////////////

  typedef logic signed [COEF_W-1:0] coef_t;
  typedef coef_t [NUM_TAPS-1:0] coef_set_t;

  typedef logic [$clog2(NUM_TAPS)-1:0] coef_idx_t;
  // One extra bit so a full set can be counted
  typedef logic [$clog2(NUM_TAPS):0] tap_count_t;

  //////////////////////////////////////////////////
  // Settings bus map
  //////////////////////////////////////////////////

  typedef enum logic [7:0] {
    SR_COEF_RELOAD      = 8'd8,
    SR_COEF_RELOAD_LAST = 8'd9,
    SR_FIR_CONFIG       = 8'd10,
    SR_READBACK         = 8'd255
  } set_addr_e;

  typedef enum logic [2:0] {
    RB_NUM_TAPS     = 3'd0,
    RB_SHADOW_COUNT = 3'd1
  } rb_sel_e;

endpackage

// File: design/fir_block_top.sv
`timescale 1ns/1ns

module fir_block_top (
  input  logic                  ce_clk,
  input  logic                  i_reset,

  // Settings bus
  input  logic                  i_set_stb,
  input  logic [7:0]            i_set_addr,
  input  logic [31:0]           i_set_data,

  // Readback
  output logic [63:0]           o_rb_data,

  // Input stream
  input  fir_pkg::stream_beat_t i_in_beat,
  input  logic                  i_in_valid,
  output logic                  o_in_ready,

  // Output stream
  output fir_pkg::stream_beat_t o_out_beat,
  output logic                  o_out_valid,
  input  logic                  i_out_ready
);

  import fir_pkg::*;

  logic       reload_stb;
  logic       reload_last;
  coef_t      reload_coef;
  logic       commit_stb;
  coef_set_t  active_coefs;
  tap_count_t shadow_count;

  //////////////////////////////////////////////////
  // Settings and coefficients
  //////////////////////////////////////////////////

  fir_settings_decode fir_settings_decode_inst (
    .ce_clk         (ce_clk),
    .i_reset        (i_reset),
    .i_set_stb      (i_set_stb),
    .i_set_addr     (i_set_addr),
    .i_set_data     (i_set_data),
    .i_shadow_count (shadow_count),
    .o_reload_stb   (reload_stb),
    .o_reload_last  (reload_last),
    .o_reload_coef  (reload_coef),
    .o_commit_stb   (commit_stb),
    .o_rb_data      (o_rb_data)
  );

  fir_coef_bank fir_coef_bank_inst (
    .ce_clk         (ce_clk),
    .i_reset        (i_reset),
    .i_reload_stb   (reload_stb),
    .i_reload_last  (reload_last),
    .i_reload_coef  (reload_coef),
    .i_commit_stb   (commit_stb),
    .o_active_coefs (active_coefs),
    .o_shadow_count (shadow_count)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  fir_mac_pipe fir_mac_pipe_inst (
    .ce_clk      (ce_clk),
    .i_reset     (i_reset),
    .i_coefs     (active_coefs),
    .i_in_beat   (i_in_beat),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out_beat  (o_out_beat),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
  );

endmodule

// File: design/fir_settings_decode.sv
`timescale 1ns/1ns

module fir_settings_decode (
  input  logic                 ce_clk,
  input  logic                 i_reset,

  // Settings bus
  input  logic                 i_set_stb,
  input  logic [7:0]           i_set_addr,
  input  logic [31:0]          i_set_data,

  // Status from the coefficient bank
  input  fir_pkg::tap_count_t  i_shadow_count,

  // Coefficient bank control
  output logic                 o_reload_stb,
  output logic                 o_reload_last,
  output fir_pkg::coef_t       o_reload_coef,
  output logic                 o_commit_stb,

  // Readback word
  output logic [63:0]          o_rb_data
);

  import fir_pkg::*;

  set_addr_e set_addr;
  rb_sel_e   rb_sel;

  logic      reload_hit;
  logic      reload_last_hit;
  logic      commit_hit;
  logic      readback_hit;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  assign set_addr = set_addr_e'(i_set_addr);

  // Either reload address carries a coefficient
  assign reload_last_hit = i_set_stb && (set_addr == SR_COEF_RELOAD_LAST);
  assign reload_hit      = (i_set_stb && (set_addr == SR_COEF_RELOAD)) || reload_last_hit;
  assign commit_hit      = i_set_stb && (set_addr == SR_FIR_CONFIG);
  assign readback_hit    = i_set_stb && (set_addr == SR_READBACK);

  //////////////////////////////////////////////////
  // Registered strobes
  //////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_reload_stb  <= 1'b0;
      o_reload_last <= 1'b0;
      o_commit_stb  <= 1'b0;
      rb_sel        <= RB_NUM_TAPS;
    end else begin
      o_reload_stb  <= reload_hit;
      o_reload_last <= reload_last_hit;
      o_commit_stb  <= commit_hit;
      if (readback_hit) begin
        rb_sel <= rb_sel_e'(i_set_data[2:0]);
      end
    end
  end

  // Coefficient word, low half of the data
  always_ff @(posedge ce_clk) begin
    if (reload_hit) begin
      o_reload_coef <= coef_t'(i_set_data[COEF_W-1:0]);
    end
  end

  //////////////////////////////////////////////////
  // Readback mux
  //////////////////////////////////////////////////

  always_comb begin
    case (rb_sel)
      RB_NUM_TAPS:     o_rb_data = 64'(NUM_TAPS);
      RB_SHADOW_COUNT: o_rb_data = 64'(i_shadow_count);
      default:         o_rb_data = RB_BAD_WORD;
    endcase
  end

endmodule

// File: dv/fir_model.svh
`ifndef FIR_MODEL_SVH
`define FIR_MODEL_SVH

// Coefficient sets as the block should hold them
coef_t   ref_shadow [NUM_TAPS];
coef_t   ref_active [NUM_TAPS];
int      ref_wr_idx;
// Newest sample in slot 0
sample_t ref_hist [NUM_TAPS];
int      sat_hi_count;
int      sat_lo_count;

// Expected output beats in arrival order
stream_beat_t expect_q [$];

function automatic void clear_model();
  for (int k = 0; k < NUM_TAPS; k++) begin
    ref_shadow[k] = '0;
    ref_active[k] = '0;
    ref_hist[k]   = '0;
  end
  ref_wr_idx   = 0;
  sat_hi_count = 0;
  sat_lo_count = 0;
  expect_q.delete();
endfunction

// Words past the last tap are dropped
function automatic void store_shadow(input coef_t coef, input bit last_word);
  if (ref_wr_idx < NUM_TAPS) begin
    ref_shadow[ref_wr_idx] = coef;
  end
  if (last_word) begin
    ref_wr_idx = 0;
  end else if (ref_wr_idx < NUM_TAPS) begin
    ref_wr_idx++;
  end
endfunction

function automatic void commit_active();
  ref_active = ref_shadow;
endfunction

function automatic logic signed [15:0] clamp_to_sample(input longint acc);
  longint shifted;
  shifted = acc >>> OUT_SHIFT;
  if (shifted > 32767) begin
    sat_hi_count++;
    return 16'sh7fff;
  end else if (shifted < -32768) begin
    sat_lo_count++;
    return 16'sh8000;
  end
  return 16'(shifted);
endfunction

function automatic void predict_beat(input stream_beat_t beat);
  longint       acc_i;
  longint       acc_q;
  stream_beat_t expected;
  for (int k = NUM_TAPS - 1; k > 0; k--) begin
    ref_hist[k] = ref_hist[k-1];
  end
  ref_hist[0] = beat.sample;
  acc_i = 0;
  acc_q = 0;
  for (int k = 0; k < NUM_TAPS; k++) begin
    acc_i += longint'(ref_active[k]) * longint'(ref_hist[k].i);
    acc_q += longint'(ref_active[k]) * longint'(ref_hist[k].q);
  end
  expected.sample.i = clamp_to_sample(acc_i);
  expected.sample.q = clamp_to_sample(acc_q);
  expected.last     = beat.last;
  expect_q.push_back(expected);
endfunction

`endif

// File: dv/fir_block_tb.sv
`timescale 1ns/1ns

module fir_block_tb;

  import fir_pkg::*;

  `include "fir_model.svh"

  logic         ce_clk;
  logic         i_reset;
  logic         i_set_stb;
  logic [7:0]   i_set_addr;
  logic [31:0]  i_set_data;
  logic [63:0]  o_rb_data;
  stream_beat_t i_in_beat;
  logic         i_in_valid;
  logic         o_in_ready;
  stream_beat_t o_out_beat;
  logic         o_out_valid;
  logic         i_out_ready;

  integer       seed = 32'h26e4_bf11;
  int           errors = 0;
  int           tests_run = 0;
  int           beats_checked = 0;
  int           stall_pct = 0;
  int           cycle = 0;
  bit           lat_armed = 0;
  int           first_in_cycle = -1;
  int           first_out_cycle = -1;
  stream_beat_t expect_head;

  fir_block_top fir_block_top_inst (
    .ce_clk      (ce_clk),
    .i_reset     (i_reset),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .o_rb_data   (o_rb_data),
    .i_in_beat   (i_in_beat),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out_beat  (o_out_beat),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
  );

  initial begin
    ce_clk = 1'b0;
    forever #2 ce_clk = ~ce_clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic int roll(input int range);
    return ($random(seed) & 32'h7fff_ffff) % range;
  endfunction

  function automatic stream_beat_t random_beat(input bit full_scale);
    stream_beat_t b;
    if (full_scale) begin
      b.sample.i = roll(2) ? 16'sh7fff : 16'sh8000;
      b.sample.q = (b.sample.i == 16'sh7fff) ? 16'sh8000 : 16'sh7fff;
    end else begin
      b.sample.i = 16'($random(seed));
      b.sample.q = 16'($random(seed));
    end
    b.last = roll(2);
    return b;
  endfunction

  task automatic report_mismatch(input string what);
    $display("Fail at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    errors++;
  endtask

  task automatic end_test(input int num, input string name, input int base);
    tests_run++;
    $display("Test %0d (%s) finished with %0d errors", num, name, errors - base);
  endtask

  task automatic drive_ready();
    if (stall_pct == 0) i_out_ready <= 1'b1;
    else i_out_ready <= (roll(100) >= stall_pct);
  endtask

  // One strobe cycle on the settings bus
  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(posedge ce_clk);
    i_set_stb  <= 1'b1;
    i_set_addr <= addr;
    i_set_data <= data;
    @(posedge ce_clk);
    i_set_stb  <= 1'b0;
  endtask

  task automatic read_back(input logic [2:0] sel, output logic [63:0] value);
    write_setting(SR_READBACK, {29'd0, sel});
    @(posedge ce_clk);
    value = o_rb_data;
  endtask

  task automatic load_coefs(input bit max_scale);
    coef_t c;
    for (int k = 0; k < NUM_TAPS; k++) begin
      c = max_scale ? 16'sh7fff : coef_t'($random(seed) % 4096);
      write_setting((k == NUM_TAPS - 1) ? SR_COEF_RELOAD_LAST : SR_COEF_RELOAD, {16'd0, c});
      store_shadow(c, k == NUM_TAPS - 1);
    end
  endtask

  task automatic commit_coefs();
    write_setting(SR_FIR_CONFIG, 32'd0);
    commit_active();
    repeat (4) @(posedge ce_clk);
  endtask

  // Holds each beat until it transfers
  task automatic send_beats(input int count, input int gap_pct, input bit full_scale);
    int sent;
    int guard;
    sent  = 0;
    guard = 0;
    while (sent < count && guard < count * 20 + 200) begin
      @(posedge ce_clk);
      guard++;
      drive_ready();
      if (i_in_valid && o_in_ready) sent++;
      if (!(i_in_valid && !o_in_ready)) begin
        if (sent >= count || roll(100) < gap_pct) begin
          i_in_valid <= 1'b0;
        end else begin
          i_in_beat  <= random_beat(full_scale);
          i_in_valid <= 1'b1;
        end
      end
    end
    if (sent < count) report_timeout("input beats to be accepted");
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    @(negedge ce_clk);
    while (expect_q.size() > 0 && waited < 500) begin
      @(posedge ce_clk);
      drive_ready();
      @(negedge ce_clk);
      waited++;
    end
    if (expect_q.size() > 0) report_timeout(what);
    repeat (2) @(posedge ce_clk);
  endtask

  //////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////

  always @(posedge ce_clk) begin
    cycle++;
    if (!i_reset) begin
      if (i_in_valid && o_in_ready) begin
        predict_beat(i_in_beat);
        if (lat_armed && first_in_cycle < 0) first_in_cycle = cycle;
      end
      if (lat_armed && o_out_valid && first_out_cycle < 0) first_out_cycle = cycle;
      if (o_out_valid && i_out_ready) begin
        beats_checked++;
        assert (expect_q.size() > 0) else begin
          $display("Output beat at %0t arrived with no beat expected", $time);
          errors++;
        end
        if (expect_q.size() > 0) begin
          expect_head = expect_q.pop_front();
          assert (o_out_beat == expect_head) else report_mismatch($sformatf(
            "out i=%0d q=%0d last=%0b, expected i=%0d q=%0d last=%0b",
            o_out_beat.sample.i, o_out_beat.sample.q, o_out_beat.last,
            expect_head.sample.i, expect_head.sample.q, expect_head.last));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int          base;
    logic [63:0] rb;
    i_reset     = 1'b1;
    i_set_stb   = 1'b0;
    i_set_addr  = '0;
    i_set_data  = '0;
    i_in_beat   = '0;
    i_in_valid  = 1'b0;
    i_out_ready = 1'b1;
    clear_model();
    repeat (16) @(posedge ce_clk);
    i_reset <= 1'b0;
    @(posedge ce_clk);

    // Zero coefficients after reset
    base = errors;
    rb = o_rb_data;
    assert (rb == 64'd8) else report_mismatch($sformatf("tap count %0d out of reset", rb));
    read_back(RB_NUM_TAPS, rb);
    assert (rb == 64'd8) else report_mismatch($sformatf("tap count readback %0d", rb));
    send_beats(24, 0, 1'b0);
    wait_drain("outputs of test 1");
    end_test(1, "reset state", base);

    base = errors;
    load_coefs(1'b0);
    read_back(RB_SHADOW_COUNT, rb);
    assert (rb == 64'd0) else report_mismatch($sformatf("shadow count %0d after reload", rb));
    commit_coefs();
    send_beats(40, 0, 1'b0);
    wait_drain("outputs of test 2");
    end_test(2, "reload and filter", base);

    // Shadow count follows each word of a partial reload
    base = errors;
    for (int k = 0; k < 3; k++) begin
      write_setting(SR_COEF_RELOAD, 32'(k + 1));
      store_shadow(coef_t'(k + 1), 1'b0);
      read_back(RB_SHADOW_COUNT, rb);
      assert (rb == 64'(k + 1)) else report_mismatch($sformatf("shadow count %0d", rb));
    end
    write_setting(SR_COEF_RELOAD_LAST, 32'd4);
    store_shadow(16'sd4, 1'b1);
    read_back(3'd5, rb);
    assert (rb == 64'h0BAD_C0DE_0BAD_C0DE) else report_mismatch($sformatf("bad select %h", rb));
    end_test(3, "readback", base);

    base = errors;
    load_coefs(1'b1);
    commit_coefs();
    sat_hi_count = 0;
    sat_lo_count = 0;
    send_beats(48, 0, 1'b1);
    wait_drain("outputs of test 4");
    assert (sat_hi_count > 0 && sat_lo_count > 0) else begin
      $display("Full scale stimulus did not reach both saturation limits");
      errors++;
    end
    end_test(4, "saturation", base);

    base = errors;
    load_coefs(1'b0);
    commit_coefs();
    stall_pct = 30;
    send_beats(60, 30, 1'b0);
    wait_drain("outputs of test 5 under stalls");
    stall_pct = 0;
    @(posedge ce_clk);
    i_out_ready <= 1'b1;
    @(posedge ce_clk);
    lat_armed = 1'b1;
    send_beats(12, 0, 1'b0);
    wait_drain("outputs of test 5 latency run");
    lat_armed = 1'b0;
    assert (first_out_cycle - first_in_cycle == 3) else report_mismatch($sformatf(
      "latency %0d cycles", first_out_cycle - first_in_cycle));
    end_test(5, "back-pressure and latency", base);

    $display("Tests run: %0d, beats checked: %0d, errors: %0d",
             tests_run, beats_checked, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: fir/fir_coef_bank.sv
`timescale 1ns/1ns

module fir_coef_bank (
  input  logic                 ce_clk,
  input  logic                 i_reset,

  // Reload and commit from the settings decoder
  input  logic                 i_reload_stb,
  input  logic                 i_reload_last,
  input  fir_pkg::coef_t       i_reload_coef,
  input  logic                 i_commit_stb,

  // Coefficients used by the MAC pipe
  output fir_pkg::coef_set_t   o_active_coefs,
  // Words loaded since the last reload restart
  output fir_pkg::tap_count_t  o_shadow_count
);

  import fir_pkg::*;

  coef_set_t  shadow_coefs;
  tap_count_t wr_idx;
  coef_idx_t  wr_slot;
  logic       has_room;

  // Index runs one past the last tap once the set is full
  assign has_room = (wr_idx < NUM_TAPS);
  assign wr_slot  = coef_idx_t'(wr_idx);

  //////////////////////////////////////////////////
  // Shadow set and write index
  //////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      shadow_coefs <= '0;
      wr_idx       <= '0;
    end else if (i_reload_stb) begin
      if (has_room) begin
        shadow_coefs[wr_slot] <= i_reload_coef;
      end
      // Last word restarts the next reload at tap 0
      if (i_reload_last) begin
        wr_idx <= '0;
      end else if (has_room) begin
        wr_idx <= wr_idx + 1'b1;
      end
    end
  end

  assign o_shadow_count = wr_idx;

  //////////////////////////////////////////////////
  // Active set
  //////////////////////////////////////////////////

  // Whole shadow set copied in a single cycle
  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_active_coefs <= '0;
    end else if (i_commit_stb) begin
      o_active_coefs <= shadow_coefs;
    end
  end

endmodule

// File: fir/fir_mac_pipe.sv
`timescale 1ns/1ns

module fir_mac_pipe (
  input  logic                  ce_clk,
  input  logic                  i_reset,

  // Active coefficient set
  input  fir_pkg::coef_set_t    i_coefs,

  // Input stream
  input  fir_pkg::stream_beat_t i_in_beat,
  input  logic                  i_in_valid,
  output logic                  o_in_ready,

  // Output stream
  output fir_pkg::stream_beat_t o_out_beat,
  output logic                  o_out_valid,
  input  logic                  i_out_ready
);

  import fir_pkg::*;

  // Arithmetic shift then clamp to the sample range
  function automatic logic signed [SAMPLE_W-1:0] shift_sat(
    input logic signed [ACC_W-1:0] acc
  );
    logic signed [ACC_W-1:0] shifted;
    logic [ACC_W-SAMPLE_W:0]  top_bits;
    shifted  = acc >>> OUT_SHIFT;
    top_bits = shifted[ACC_W-1:SAMPLE_W-1];
    if ((&top_bits) || (~|top_bits)) begin
      return shifted[SAMPLE_W-1:0];
    end else if (shifted[ACC_W-1]) begin
      return {1'b1, {(SAMPLE_W-1){1'b0}}};
    end else begin
      return {1'b0, {(SAMPLE_W-1){1'b1}}};
    end
  endfunction

  // Stage valids and advance conditions
  logic v1, v2, v3;
  logic adv1, adv2, adv3;
  logic accept;

  sample_t [NUM_TAPS-1:0] taps;
  sample_t [NUM_TAPS-1:0] taps_next;

  logic signed [PROD_W-1:0] prod_i [NUM_TAPS];
  logic signed [PROD_W-1:0] prod_q [NUM_TAPS];
  logic                     last1;

  logic signed [ACC_W-1:0]  part_i_next [2];
  logic signed [ACC_W-1:0]  part_q_next [2];
  logic signed [ACC_W-1:0]  part_i [2];
  logic signed [ACC_W-1:0]  part_q [2];
  logic                     last2;

  logic signed [ACC_W-1:0]  sum_i;
  logic signed [ACC_W-1:0]  sum_q;

  //////////////////////////////////////////////////
  // Flow control
  //////////////////////////////////////////////////

  assign adv3       = !v3 || i_out_ready;
  assign adv2       = !v2 || adv3;
  assign adv1       = !v1 || adv2;
  assign o_in_ready = adv1;
  assign accept     = i_in_valid && adv1;

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else begin
      if (adv1) v1 <= i_in_valid;
      if (adv2) v2 <= v1;
      if (adv3) v3 <= v2;
    end
  end

  //////////////////////////////////////////////////
  // Stage 1, delay line and products
  //////////////////////////////////////////////////

  // Tap 0 holds the newest sample
  assign taps_next = {taps[NUM_TAPS-2:0], i_in_beat.sample};

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      taps <= '0;
    end else if (accept) begin
      taps <= taps_next;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (accept) begin
      last1 <= i_in_beat.last;
      for (int k = 0; k < NUM_TAPS; k++) begin
        prod_i[k] <= i_coefs[k] * taps_next[k].i;
        prod_q[k] <= i_coefs[k] * taps_next[k].q;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stage 2, partial sums
  //////////////////////////////////////////////////

  // Lower and upper half of the taps
  always_comb begin
    for (int h = 0; h < 2; h++) begin
      part_i_next[h] = '0;
      part_q_next[h] = '0;
      for (int k = h * (NUM_TAPS / 2); k < (h + 1) * (NUM_TAPS / 2); k++) begin
        part_i_next[h] += ACC_W'(prod_i[k]);
        part_q_next[h] += ACC_W'(prod_q[k]);
      end
    end
  end

  always_ff @(posedge ce_clk) begin
    if (adv2 && v1) begin
      last2 <= last1;
      for (int h = 0; h < 2; h++) begin
        part_i[h] <= part_i_next[h];
        part_q[h] <= part_q_next[h];
      end
    end
  end

  //////////////////////////////////////////////////
  // Stage 3, final sum and output register
  //////////////////////////////////////////////////

  assign sum_i = part_i[0] + part_i[1];
  assign sum_q = part_q[0] + part_q[1];

  // Held while the sink stalls
  always_ff @(posedge ce_clk) begin
    if (adv3 && v2) begin
      o_out_beat.sample.i <= shift_sat(sum_i);
      o_out_beat.sample.q <= shift_sat(sum_q);
      o_out_beat.last     <= last2;
    end
  end

  assign o_out_valid = v3;

endmodule

// File: src.f
+incdir+dv
common/fir_pkg.sv
fir/fir_coef_bank.sv
fir/fir_mac_pipe.sv
design/fir_settings_decode.sv
design/fir_block_top.sv
dv/fir_block_tb.sv
